//--- build.f
rtl/hdc_pkg.sv
rtl/dim_counter.sv
rtl/counter_bank.sv
rtl/bundle_ctrl.sv
rtl/hv_stream_out.sv
rtl/hdc_bundler_top.sv
bench/clk_gen.sv
bench/tb_hdc_bundler.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_hdc_bundler -f build.f -o sim_tb &&
    ./obj_dir/sim_tb | tee sim.log ||
    echo "build or simulation returned an error"
grep -qs "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- bench/tb_hdc_bundler.sv
`timescale 1ns/1ns

module tb_hdc_bundler;

    localparam int DIM        = 64;
    localparam int NUM_CORES  = 2;
    localparam int CNT_W      = 4;
    localparam int STREAM_W   = 16;
    localparam int NUM_WORDS  = DIM / STREAM_W;
    localparam int BCOUNT_W   = hdc_pkg::BCOUNT_W;
    localparam int CNT_MAX    = (1 << (CNT_W - 1)) - 1;
    localparam int CNT_MIN    = -(1 << (CNT_W - 1));
    localparam int BCOUNT_MAX = (1 << BCOUNT_W) - 1;
    // generous bound in cycles on any single wait
    localparam int WAIT_LIMIT = 4 * NUM_WORDS + 8;

    typedef logic [NUM_CORES-1:0][DIM-1:0] hv_t;

    logic                  clk;
    logic                  arst_n;
    hdc_pkg::cmd_t         cmd;
    hv_t                   core_hv;
    hdc_pkg::stream_word_t stream;
    logic                  busy;
    logic [BCOUNT_W-1:0]   bundle_count;

    // reference model state
    int             model_cnt [DIM];
    int             model_bcount;
    // edges still ignored by a running dump
    int             busy_left;
    // edges since the accepted dump or -1 when idle
    int             dump_age;
    logic [DIM-1:0] snap;

    integer seed = 82;
    int     n_word_err;
    int     n_count_err;
    int     n_busy_err;
    int     n_timing_err;
    int     n_timeout;
    bit     timed_out;
    // words seen on the stream during the last dump
    hdc_pkg::stream_word_t dumped [$];

    clk_gen u_clk (
        .clk    (clk),
        .arst_n (arst_n)
    );

    hdc_bundler_top #(
        .DIM       (DIM),
        .NUM_CORES (NUM_CORES),
        .CNT_W     (CNT_W),
        .STREAM_W  (STREAM_W)
    ) dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .cmd          (cmd),
        .core_hv      (core_hv),
        .stream       (stream),
        .busy         (busy),
        .bundle_count (bundle_count)
    );

    task automatic check_word(input hdc_pkg::stream_word_t got,
                              input hdc_pkg::stream_word_t exp, input string what);
        // data only matters on valid words
        if (got.valid !== exp.valid || got.last !== exp.last ||
            (exp.valid && got.data !== exp.data)) begin
            n_word_err++;
            $display("FAILED at %0t ns: %s stream v=%b l=%b d=%h, expected v=%b l=%b d=%h",
                     $time, what, got.valid, got.last, got.data,
                     exp.valid, exp.last, exp.data);
        end
    endtask

    task automatic check_count(input logic [BCOUNT_W-1:0] got,
                               input logic [BCOUNT_W-1:0] exp, input string what);
        if (got !== exp) begin
            n_count_err++;
            $display("FAILED at %0t ns: %s bundle_count %0d, expected %0d",
                     $time, what, got, exp);
        end
    endtask

    task automatic check_busy(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            n_busy_err++;
            $display("FAILED at %0t ns: %s busy %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_latency(input int got, input int exp, input string what);
        if (got != exp) begin
            n_timing_err++;
            $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic report_timeout(input string what, input int limit);
        n_timeout++;
        timed_out = 1'b1;
        $display("Timed out after %0d cycles waiting for the %s", limit, what);
    endtask

    function automatic int clamp(input int v);
        if (v > CNT_MAX) begin
            return CNT_MAX;
        end
        if (v < CNT_MIN) begin
            return CNT_MIN;
        end
        return v;
    endfunction

    // ties and negative counters give 0
    function automatic logic [DIM-1:0] model_sign();
        logic [DIM-1:0] v;
        for (int j = 0; j < DIM; j++) begin
            v[j] = (model_cnt[j] > 0);
        end
        return v;
    endfunction

    // one rising edge of the model
    task automatic model_edge(input hdc_pkg::cmd_t c, input hv_t hv);
        int delta;
        int added;
        if (dump_age >= 0) begin
            dump_age++;
            if (dump_age > NUM_WORDS + 1) begin
                dump_age = -1;
            end
        end
        if (busy_left > 0) begin
            // whole command dropped while a dump is in flight
            busy_left--;
        end else begin
            added = 0;
            for (int k = 0; k < NUM_CORES; k++) begin
                if (c.store[k]) begin
                    added++;
                end
            end
            if (c.clear) begin
                for (int j = 0; j < DIM; j++) begin
                    model_cnt[j] = 0;
                end
                model_bcount = 0;
            end else if (added > 0) begin
                for (int j = 0; j < DIM; j++) begin
                    // whole step first and a single clamp
                    delta = 0;
                    for (int k = 0; k < NUM_CORES; k++) begin
                        if (c.store[k]) begin
                            delta += hv[k][j] ? 1 : -1;
                        end
                    end
                    model_cnt[j] = clamp(model_cnt[j] + delta);
                end
                model_bcount = (model_bcount + added > BCOUNT_MAX) ? BCOUNT_MAX
                                                                   : model_bcount + added;
            end
            // snapshot taken after this edge's store or clear
            if (c.dump) begin
                busy_left = NUM_WORDS + 1;
                dump_age  = 0;
                snap      = model_sign();
            end
        end
    endtask

    // word k shows two edges after the dump edge plus k
    function automatic hdc_pkg::stream_word_t expected_word();
        hdc_pkg::stream_word_t w;
        w = '0;
        if (dump_age >= 2) begin
            w.valid = 1'b1;
            w.last  = (dump_age == NUM_WORDS + 1);
            w.data  = snap[(dump_age - 2) * STREAM_W +: STREAM_W];
        end
        return w;
    endfunction

    task automatic check_all(input string what);
        check_busy(busy, busy_left > 0, what);
        check_count(bundle_count, BCOUNT_W'(model_bcount), what);
        check_word(stream, expected_word(), what);
    endtask

    function automatic hv_t random_hv();
        hv_t v;
        for (int k = 0; k < NUM_CORES; k++) begin
            v[k] = {$random(seed), $random(seed)};
        end
        return v;
    endfunction

    // random stores plus dumps and clears when noisy
    function automatic hdc_pkg::cmd_t random_cmd(input bit noisy);
        hdc_pkg::cmd_t c;
        logic [31:0]   r;
        r       = $random(seed);
        c       = '0;
        c.store = r[NUM_CORES-1:0];
        if (noisy) begin
            c.dump  = r[8];
            c.clear = r[9] & r[10];
        end
        return c;
    endfunction

    function automatic hdc_pkg::cmd_t make_cmd(input logic clr, input logic dmp,
                                               input logic [NUM_CORES-1:0] st);
        hdc_pkg::cmd_t c;
        c       = '0;
        c.clear = clr;
        c.dump  = dmp;
        c.store = st;
        return c;
    endfunction

    // drive on the falling edge and model the rising edge
    // outputs are checked at the next fall
    task automatic step(input hdc_pkg::cmd_t c, input hv_t hv, input string what);
        if (timed_out) begin
            return;
        end
        cmd     = c;
        core_hv = hv;
        @(posedge clk);
        model_edge(c, hv);
        @(negedge clk);
        check_all(what);
    endtask

    // issue a dump while idle and collect the burst
    task automatic run_dump(input bit noisy, input logic [NUM_CORES-1:0] store_with);
        int waited;
        if (timed_out) begin
            return;
        end
        dumped.delete();
        step(make_cmd(1'b0, 1'b1, store_with), random_hv(), "dump issue");
        check_busy(busy, 1'b1, "right after dump edge");
        waited = 0;
        while (!timed_out && stream.valid !== 1'b1) begin
            if (waited >= WAIT_LIMIT) begin
                report_timeout("first stream word", WAIT_LIMIT);
            end else begin
                step(random_cmd(noisy), random_hv(), "dump lead-in");
                waited++;
            end
        end
        if (timed_out) begin
            return;
        end
        check_latency(waited, 2, "edges from dump to first word");
        dumped.push_back(stream);
        waited = 0;
        while (!timed_out && stream.last !== 1'b1) begin
            if (waited >= WAIT_LIMIT) begin
                report_timeout("last stream word", WAIT_LIMIT);
            end else begin
                step(random_cmd(noisy), random_hv(), "dump burst");
                waited++;
                if (stream.valid !== 1'b1) begin
                    n_timing_err++;
                    $display("FAILED at %0t ns: gap in the stream before the last word", $time);
                end else begin
                    dumped.push_back(stream);
                end
            end
        end
        if (timed_out) begin
            return;
        end
        check_latency(dumped.size(), NUM_WORDS, "words in dump");
        check_busy(busy, 1'b0, "with the last word");
    endtask

    // compares the collected burst against a known sign vector
    task automatic check_dump(input logic [DIM-1:0] exp_vec, input string what);
        hdc_pkg::stream_word_t w;
        for (int k = 0; k < dumped.size(); k++) begin
            w       = '0;
            w.valid = 1'b1;
            w.last  = (k == NUM_WORDS - 1);
            w.data  = exp_vec[k * STREAM_W +: STREAM_W];
            check_word(dumped[k], w, what);
        end
    endtask

    initial begin
        int             waited;
        int             n;
        logic [31:0]    r32;
        logic [DIM-1:0] pat;
        cmd          = '0;
        core_hv      = '0;
        model_bcount = 0;
        busy_left    = 0;
        dump_age     = -1;
        snap         = '0;
        for (int j = 0; j < DIM; j++) begin
            model_cnt[j] = 0;
        end

        waited = 0;
        while (!timed_out && arst_n !== 1'b1) begin
            if (waited >= 4 * WAIT_LIMIT) begin
                report_timeout("reset release", 4 * WAIT_LIMIT);
            end else begin
                @(posedge clk);
                waited++;
            end
        end
        @(negedge clk);

        // reset state and then a dump of all ties
        check_all("after reset");
        run_dump(1'b0, '0);
        check_dump('0, "dump after reset");

        // random stores
        // the dump sometimes shares its cycle with a store
        for (int r = 0; r < 24; r++) begin
            r32 = $random(seed);
            n   = 1 + int'(r32[3:0]);
            for (int i = 0; i < n; i++) begin
                step(random_cmd(1'b0), random_hv(), "random store");
            end
            r32 = $random(seed);
            run_dump(1'b0, r32[NUM_CORES-1:0]);
        end

        // saturate both ways and count back from the clamps
        pat = 64'hFFFF_0000_F0F0_3C3C;
        step(make_cmd(1'b1, 1'b0, '0), '0, "clear");
        for (int i = 0; i < 12; i++) begin
            step(make_cmd(1'b0, 1'b0, '1), {pat, pat}, "saturate");
        end
        run_dump(1'b0, '0);
        check_dump(pat, "saturated");
        for (int i = 0; i < 4; i++) begin
            step(make_cmd(1'b0, 1'b0, '1), {~pat, ~pat}, "unwind");
        end
        run_dump(1'b0, '0);
        check_dump('0, "unwound to ties");
        step(make_cmd(1'b0, 1'b0, '1), {~pat, ~pat}, "unwind");
        run_dump(1'b0, '0);
        check_dump(~pat, "past the ties");

        // commands thrown at a busy DUT during back to back dumps
        for (int r = 0; r < 8; r++) begin
            for (int i = 0; i < 5; i++) begin
                step(random_cmd(1'b0), random_hv(), "store before noisy dump");
            end
            r32 = $random(seed);
            run_dump(1'b1, r32[NUM_CORES-1:0]);
            run_dump(1'b1, '0);
        end

        // clear beats a store in the same cycle
        for (int i = 0; i < 6; i++) begin
            step(random_cmd(1'b0), random_hv(), "store before clear");
        end
        step(make_cmd(1'b1, 1'b0, '1), random_hv(), "clear with store");
        check_count(bundle_count, '0, "clear with store");
        run_dump(1'b0, '0);
        check_dump('0, "dump after clear");

        $display("errors: word %0d, count %0d, busy %0d, timing %0d, timeout %0d",
                 n_word_err, n_count_err, n_busy_err, n_timing_err, n_timeout);
        if (n_word_err + n_count_err + n_busy_err + n_timing_err + n_timeout == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- bench/clk_gen.sv
`timescale 1ns/1ns

module clk_gen #(
    parameter int HALF_PERIOD  = 2,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic arst_n
);

    // free running 4 ns clock
    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // reset held low for a fixed number of rising edges
    // released on the following falling edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

//--- rtl/hdc_bundler_top.sv
`timescale 1ns/1ns
`default_nettype none

module hdc_bundler_top #(
    parameter int DIM       = hdc_pkg::DIM_DEF,
    parameter int NUM_CORES = hdc_pkg::NUM_CORES_DEF,
    parameter int CNT_W     = hdc_pkg::CNT_W_DEF,
    parameter int STREAM_W  = hdc_pkg::STREAM_W_DEF
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  hdc_pkg::cmd_t                 cmd,
    input  logic [NUM_CORES-1:0][DIM-1:0] core_hv,
    output hdc_pkg::stream_word_t         stream,
    output logic                          busy,
    output logic [hdc_pkg::BCOUNT_W-1:0]  bundle_count
);

    localparam int NUM_WORDS = DIM / STREAM_W;
    localparam int IDX_W     = (NUM_WORDS > 1) ? $clog2(NUM_WORDS) : 1;

    logic [NUM_CORES-1:0] add_en;
    logic                 clear;
    logic [IDX_W-1:0]     word_sel;
    logic                 emit;
    logic                 emit_last;
    logic [DIM-1:0]       sign_vec;

    bundle_ctrl #(
        .NUM_CORES (NUM_CORES),
        .DIM       (DIM),
        .STREAM_W  (STREAM_W)
    ) u_ctrl (
        .clk          (clk),
        .arst_n       (arst_n),
        .cmd          (cmd),
        .add_en       (add_en),
        .clear        (clear),
        .word_sel     (word_sel),
        .emit         (emit),
        .emit_last    (emit_last),
        .busy         (busy),
        .bundle_count (bundle_count)
    );

    // one saturating counter per dimension
    counter_bank #(
        .DIM       (DIM),
        .NUM_CORES (NUM_CORES),
        .CNT_W     (CNT_W)
    ) u_bank (
        .clk      (clk),
        .arst_n   (arst_n),
        .clear    (clear),
        .add_en   (add_en),
        .core_hv  (core_hv),
        .sign_vec (sign_vec)
    );

    hv_stream_out #(
        .DIM      (DIM),
        .STREAM_W (STREAM_W)
    ) u_out (
        .clk       (clk),
        .arst_n    (arst_n),
        .sign_vec  (sign_vec),
        .word_sel  (word_sel),
        .emit      (emit),
        .emit_last (emit_last),
        .stream    (stream)
    );

endmodule

`default_nettype wire

//--- rtl/hv_stream_out.sv
`timescale 1ns/1ns
`default_nettype none

module hv_stream_out #(
    parameter int DIM         = hdc_pkg::DIM_DEF,
    parameter int STREAM_W    = hdc_pkg::STREAM_W_DEF,
    localparam int NUM_WORDS  = DIM / STREAM_W,
    localparam int IDX_W      = (NUM_WORDS > 1) ? $clog2(NUM_WORDS) : 1
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [DIM-1:0]        sign_vec,
    input  logic [IDX_W-1:0]      word_sel,
    input  logic                  emit,
    input  logic                  emit_last,
    output hdc_pkg::stream_word_t stream
);

    // data field of the stream word is fixed by the package
    if (STREAM_W != $bits(stream.data)) begin : g_bad_width
        $error("STREAM_W must match the stream_word_t data width");
    end

    // sign vector viewed as words with the lowest bits in word 0
    logic [NUM_WORDS-1:0][STREAM_W-1:0] words;

    assign words = sign_vec;

    // flags follow emit and the payload holds between words
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stream <= '0;
        end else begin
            stream.valid <= emit;
            stream.last  <= emit && emit_last;
            if (emit) begin
                stream.data <= words[word_sel];
            end
        end
    end

    // a dump ends with last and a gap before the next one
    a_last_valid : assert property (
        @(posedge clk) disable iff (!arst_n)
        stream.last |-> stream.valid ##1 !stream.valid
    );

endmodule

`default_nettype wire

//--- rtl/bundle_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module bundle_ctrl #(
    parameter int NUM_CORES   = hdc_pkg::NUM_CORES_DEF,
    parameter int DIM         = hdc_pkg::DIM_DEF,
    parameter int STREAM_W    = hdc_pkg::STREAM_W_DEF,
    localparam int NUM_WORDS  = DIM / STREAM_W,
    localparam int IDX_W      = (NUM_WORDS > 1) ? $clog2(NUM_WORDS) : 1
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  hdc_pkg::cmd_t                 cmd,
    output logic [NUM_CORES-1:0]          add_en,
    output logic                          clear,
    output logic [IDX_W-1:0]              word_sel,
    output logic                          emit,
    output logic                          emit_last,
    output logic                          busy,
    output logic [hdc_pkg::BCOUNT_W-1:0]  bundle_count
);

    localparam int ADD_W  = $clog2(NUM_CORES + 1);
    localparam int CSUM_W = hdc_pkg::BCOUNT_W + 1;

    // only whole stream words are supported
    if (DIM % STREAM_W != 0) begin : g_bad_words
        $error("DIM must be a multiple of STREAM_W");
    end
    if (NUM_CORES > $bits(cmd.store)) begin : g_bad_cores
        $error("NUM_CORES exceeds the store field of cmd_t");
    end

    // idle, one lead cycle, then one cycle per word
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_SEND
    } state_t;

    state_t             state;
    logic               dump_go;
    logic [ADD_W-1:0]   n_added;
    logic [CSUM_W-1:0]  count_sum;

    assign busy = (state != ST_IDLE);

    // stores, clears and dumps only land while idle
    // keeps the counters frozen for the whole dump
    assign add_en  = cmd.store[NUM_CORES-1:0] & {NUM_CORES{!busy}};
    assign clear   = cmd.clear && !busy;
    assign dump_go = cmd.dump && !busy;

    // number of vectors stored this cycle
    always_comb begin
        n_added = '0;
        for (int c = 0; c < NUM_CORES; c++) begin
            n_added = n_added + ADD_W'(add_en[c]);
        end
    end

    assign count_sum = {1'b0, bundle_count} + CSUM_W'(n_added);

    // saturating bundle count, clear first
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bundle_count <= '0;
        end else if (clear) begin
            bundle_count <= '0;
        end else if (count_sum[CSUM_W-1]) begin
            bundle_count <= '1;
        end else begin
            bundle_count <= count_sum[CSUM_W-2:0];
        end
    end

    // dump sequencer
    // word k is presented after edge e+1+k, last one after e+NUM_WORDS
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_IDLE;
            word_sel  <= '0;
            emit      <= 1'b0;
            emit_last <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (dump_go) begin
                        state <= ST_START;
                    end
                end
                ST_START: begin
                    state     <= ST_SEND;
                    word_sel  <= '0;
                    emit      <= 1'b1;
                    emit_last <= (NUM_WORDS == 1);
                end
                ST_SEND: begin
                    if (emit_last) begin
                        // busy drops as the last word is registered downstream
                        state     <= ST_IDLE;
                        emit      <= 1'b0;
                        emit_last <= 1'b0;
                    end else begin
                        word_sel  <= word_sel + 1'b1;
                        emit_last <= (int'(word_sel) + 2 == NUM_WORDS);
                    end
                end
                default: begin
                    state <= ST_IDLE;
                    emit  <= 1'b0;
                end
            endcase
        end
    end

    a_word_range : assert property (
        @(posedge clk) disable iff (!arst_n)
        emit |-> (int'(word_sel) < NUM_WORDS)
    );

    // last closes the burst, no word follows it
    a_last_ends_burst : assert property (
        @(posedge clk) disable iff (!arst_n)
        emit_last |-> emit ##1 !emit
    );

endmodule

`default_nettype wire

//--- rtl/counter_bank.sv
`timescale 1ns/1ns
`default_nettype none

module counter_bank #(
    parameter int DIM       = hdc_pkg::DIM_DEF,
    parameter int NUM_CORES = hdc_pkg::NUM_CORES_DEF,
    parameter int CNT_W     = hdc_pkg::CNT_W_DEF
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          clear,
    input  logic [NUM_CORES-1:0]          add_en,
    input  logic [NUM_CORES-1:0][DIM-1:0] core_hv,
    output logic [DIM-1:0]                sign_vec
);

    // core vectors turned around, one slice of core bits per dimension
    logic [DIM-1:0][NUM_CORES-1:0] dim_bits;

    for (genvar j = 0; j < DIM; j++) begin : g_dim

        // core order kept, core 0 in bit 0
        for (genvar c = 0; c < NUM_CORES; c++) begin : g_core
            assign dim_bits[j][c] = core_hv[c][j];
        end

        dim_counter #(
            .CNT_W     (CNT_W),
            .NUM_CORES (NUM_CORES)
        ) u_cnt (
            .clk      (clk),
            .arst_n   (arst_n),
            .clear    (clear),
            .add_en   (add_en),
            .bits     (dim_bits[j]),
            .sign_bit (sign_vec[j])
        );

    end

endmodule

`default_nettype wire

//--- rtl/dim_counter.sv
`timescale 1ns/1ns
`default_nettype none

module dim_counter #(
    parameter int CNT_W     = hdc_pkg::CNT_W_DEF,
    parameter int NUM_CORES = hdc_pkg::NUM_CORES_DEF
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 clear,
    input  logic [NUM_CORES-1:0] add_en,
    input  logic [NUM_CORES-1:0] bits,
    output logic                 sign_bit
);

    // headroom for counter plus the largest per-cycle step
    localparam int SUM_W = CNT_W + $clog2(NUM_CORES + 1) + 1;

    localparam logic signed [CNT_W-1:0] CNT_MAX = {1'b0, {(CNT_W - 1){1'b1}}};
    localparam logic signed [CNT_W-1:0] CNT_MIN = {1'b1, {(CNT_W - 1){1'b0}}};
    localparam logic signed [SUM_W-1:0] ONE     = 1;

    logic signed [CNT_W-1:0] cnt;
    logic signed [SUM_W-1:0] delta;
    logic signed [SUM_W-1:0] sum;
    logic signed [CNT_W-1:0] cnt_next;

    // ones minus zeros over the enabled cores
    always_comb begin
        delta = '0;
        for (int c = 0; c < NUM_CORES; c++) begin
            if (add_en[c]) begin
                delta = bits[c] ? delta + ONE : delta - ONE;
            end
        end
    end

    // widen, add, then clamp to the signed range
    always_comb begin
        sum = SUM_W'(cnt) + delta;
        if (sum > SUM_W'(CNT_MAX)) begin
            cnt_next = CNT_MAX;
        end else if (sum < SUM_W'(CNT_MIN)) begin
            cnt_next = CNT_MIN;
        end else begin
            cnt_next = CNT_W'(sum);
        end
    end

    // clear has priority over any store
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
        end else if (clear) begin
            cnt <= '0;
        end else if (|add_en) begin
            cnt <= cnt_next;
        end
    end

    // strictly positive only, a tie reads as 0
    assign sign_bit = !cnt[CNT_W-1] && (cnt != '0);

    // a wrap would show up as a jump larger than one step per core
    a_no_wrap : assert property (
        @(posedge clk) disable iff (!arst_n)
        !clear |=> (int'(cnt) - int'($past(cnt)) <= NUM_CORES) &&
                   (int'($past(cnt)) - int'(cnt) <= NUM_CORES)
    );

endmodule

`default_nettype wire

//--- rtl/hdc_pkg.sv
package hdc_pkg;

    // default sizes, passed down by the top level
    // number of hypervector dimensions
    localparam int DIM_DEF       = 64;
    // compute cores feeding the bundler
    localparam int NUM_CORES_DEF = 2;
    // per-dimension counter width, signed
    localparam int CNT_W_DEF     = 8;
    // sign vector is streamed in words of this width
    localparam int STREAM_W_DEF  = 16;

    // bundle count width, saturates at all ones
    localparam int BCOUNT_W      = 16;

    // command word sampled every rising edge
    // clear wins over store in the same cycle
    typedef struct packed {
        // zero all counters and the bundle count
        logic                     clear;
        // start streaming the sign vector
        logic                     dump;
        // one store strobe per core, core 0 in bit 0
        logic [NUM_CORES_DEF-1:0] store;
    } cmd_t;

    // one word of the outgoing sign stream
    // no back-pressure, taken every cycle valid is high
    typedef struct packed {
        logic                    valid;
        // high on the final word of a dump only
        logic                    last;
        // lowest sign bits come in word 0
        logic [STREAM_W_DEF-1:0] data;
    } stream_word_t;

endpackage
